// ==== design/axi_mem_pkg.sv ====
// AXI memory bridge shared definitions.
// Holds the bus widths, the AXI channel payloads and the internal beat and
// memory request formats used by every block of the bridge.
`default_nettype none

package axi_mem_pkg;

  // Bus widths.
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned SIZE_W = 3;

  // Memory requests allowed in flight.
  // The beat buffer holds one entry more.
  localparam int unsigned BUF_DEPTH = 2;

  // Only OKAY is ever returned.
  localparam logic [1:0] RESP_OKAY = 2'd0;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SIZE_W-1:0] size_t;

  // AR or AW request, INCR bursts only.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    size_t size;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } r_chan_t;

  // One beat as produced by a burst generator.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    size_t size;
    logic  last;
    logic  write;
  } beat_meta_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== design/stream_buffer.sv ====
// Fall-through stream FIFO.
// Circular buffer of DEPTH entries with valid/ready on both sides.
// When empty, the input is presented at the output in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module stream_buffer #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  T          data_i,
  input  wire logic valid_i,
  output logic      ready_o,
  output T          data_o,
  output logic      valid_o,
  input  wire logic ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                   mem_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   cnt_q;
  logic               empty, push, pop;

  assign empty   = (cnt_q == '0);
  assign ready_o = (cnt_q != CNT_W'(DEPTH));
  assign valid_o = ~empty | valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  // A beat passing straight through is neither stored nor popped.
  assign push = valid_i & ready_o & ~(empty & ready_i);
  assign pop  = ready_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_burst_gen.sv ====
// Burst generator.
// Takes one AR or AW request and emits one beat per transfer of the burst.
// The first beat carries the address as given, later beats step from the
// aligned address by the beat size. Write beats wait for W data.
`timescale 1ns/1ps
`default_nettype none

module axi_burst_gen #(
  parameter bit IS_WRITE = 1'b0
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  axi_mem_pkg::ax_chan_t       ax_i,
  input  wire logic                   ax_valid_i,
  output logic                        ax_ready_o,
  input  wire logic                   w_valid_i,
  output axi_mem_pkg::beat_meta_t     beat_o,
  output logic                        beat_valid_o,
  input  wire logic                   beat_ready_i,
  output logic                        burst_active_o
);

  // Beats still to come after the current one.
  axi_mem_pkg::len_t       cnt_q, cnt_d;
  // Last issued beat, with the aligned address.
  axi_mem_pkg::beat_meta_t meta_q, meta_d;
  axi_mem_pkg::addr_t      size_mask;
  logic                    data_ok;

  // Reads never wait for data.
  assign data_ok = !IS_WRITE || w_valid_i;

  // Low address bits cleared by alignment.
  assign size_mask = (axi_mem_pkg::addr_t'(1) << ax_i.size) - axi_mem_pkg::addr_t'(1);

  assign burst_active_o = (cnt_q != '0);

  always_comb begin
    ax_ready_o   = 1'b0;
    beat_valid_o = 1'b0;
    beat_o       = meta_q;
    cnt_d        = cnt_q;
    meta_d       = meta_q;
    if (cnt_q != '0) begin
      // Burst in progress, step from the aligned address.
      beat_o.addr  = meta_q.addr + (axi_mem_pkg::addr_t'(1) << meta_q.size);
      beat_o.last  = (cnt_q == axi_mem_pkg::len_t'(1));
      beat_valid_o = data_ok;
      if (data_ok && beat_ready_i) begin
        cnt_d       = cnt_q - axi_mem_pkg::len_t'(1);
        meta_d.addr = beat_o.addr;
      end
    end else if (ax_valid_i && data_ok) begin
      // New request, first beat uses the unaligned address.
      beat_o.id    = ax_i.id;
      beat_o.addr  = ax_i.addr;
      beat_o.size  = ax_i.size;
      beat_o.last  = (ax_i.len == '0);
      beat_o.write = IS_WRITE;
      beat_valid_o = 1'b1;
      if (beat_ready_i) begin
        ax_ready_o  = 1'b1;
        cnt_d       = ax_i.len;
        meta_d      = beat_o;
        meta_d.addr = ax_i.addr & ~size_mask;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Beat payload needs no reset.
  always_ff @(posedge clk_i) begin
    meta_q <= meta_d;
  end

endmodule

`default_nettype wire

// ==== design/beat_arbiter.sv ====
// Read/write beat arbiter.
// Picks one of the two beat streams, holds the choice under back-pressure
// and forks the winner to the beat buffer and to the memory port.
// The memory request takes its write data from the current W beat.
`timescale 1ns/1ps
`default_nettype none

module beat_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  axi_mem_pkg::beat_meta_t     rd_beat_i,
  input  wire logic                   rd_valid_i,
  output logic                        rd_ready_o,
  input  axi_mem_pkg::beat_meta_t     wr_beat_i,
  input  wire logic                   wr_valid_i,
  output logic                        wr_ready_o,
  input  wire logic                   rd_active_i,
  input  wire logic                   wr_active_i,
  input  axi_mem_pkg::w_chan_t        w_i,
  output logic                        w_ready_o,
  output axi_mem_pkg::beat_meta_t     meta_o,
  output logic                        meta_valid_o,
  input  wire logic                   meta_ready_i,
  output axi_mem_pkg::mem_req_t       mem_req_o,
  output logic                        mem_valid_o,
  input  wire logic                   mem_ready_i
);

  // Choice, 1 selects the write side.
  logic       sel_q, sel_d;
  logic       lock_q;
  logic       arb_valid, arb_ready;
  // Fork legs already served: bit 0 buffer, bit 1 memory.
  logic [1:0] done_q, done_d;

  always_comb begin
    sel_d = sel_q;
    if (!lock_q) begin
      if (wr_valid_i ^ rd_valid_i) begin
        sel_d = wr_valid_i;
      end else if (wr_valid_i && rd_valid_i) begin
        // Single write beats cannot be interleaved, so they go first.
        if (wr_beat_i.last && !rd_beat_i.last) begin
          sel_d = 1'b1;
        end else if (wr_active_i) begin
          sel_d = 1'b1;
        end else if (rd_active_i) begin
          sel_d = 1'b0;
        end else begin
          // Round robin.
          sel_d = ~sel_q;
        end
      end
    end
  end

  assign arb_valid = sel_d ? wr_valid_i : rd_valid_i;
  assign meta_o    = sel_d ? wr_beat_i : rd_beat_i;

  // Fork completes once both legs have taken the beat.
  assign arb_ready    = (meta_ready_i | done_q[0]) & (mem_ready_i | done_q[1]);
  assign meta_valid_o = arb_valid & ~done_q[0];
  assign mem_valid_o  = arb_valid & ~done_q[1];

  assign rd_ready_o = ~sel_d & arb_ready;
  assign wr_ready_o = sel_d & arb_ready;
  // W is consumed together with its write beat.
  assign w_ready_o  = sel_d & wr_valid_i & arb_ready;

  assign mem_req_o.addr  = meta_o.addr;
  assign mem_req_o.wdata = w_i.data;
  assign mem_req_o.strb  = meta_o.write ? w_i.strb : '0;
  assign mem_req_o.we    = meta_o.write;

  always_comb begin
    if (arb_valid && arb_ready) begin
      done_d = 2'b00;
    end else begin
      done_d[0] = done_q[0] | (meta_valid_o & meta_ready_i);
      done_d[1] = done_q[1] | (mem_valid_o & mem_ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
      done_q <= 2'b00;
    end else begin
      sel_q  <= sel_d;
      // Hold the choice until the beat is fully forked.
      lock_q <= arb_valid & ~arb_ready;
      done_q <= done_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_req_port.sv ====
// Memory request port.
// Forwards requests to the memory while a response slot is free and
// captures every memory response, since rvalid cannot be stalled.
// Outstanding plus buffered responses never exceed BUF_DEPTH.
`timescale 1ns/1ps
`default_nettype none

module mem_req_port (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  axi_mem_pkg::mem_req_t    req_i,
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  output axi_mem_pkg::data_t       resp_o,
  output logic                     resp_valid_o,
  input  wire logic                resp_ready_i,
  output axi_mem_pkg::mem_req_t    mem_o,
  output logic                     mem_req_o,
  input  wire logic                mem_gnt_i,
  input  wire logic                mem_rvalid_i,
  input  axi_mem_pkg::data_t       mem_rdata_i
);

  localparam int unsigned CNT_W = $clog2(axi_mem_pkg::BUF_DEPTH + 1);

  // Requests in flight or waiting in the response buffer.
  logic [CNT_W-1:0] credit_q;
  logic             slot_free, issue, retire;

  assign slot_free = (credit_q < CNT_W'(axi_mem_pkg::BUF_DEPTH));

  assign mem_o       = req_i;
  assign mem_req_o   = req_valid_i & slot_free;
  assign req_ready_o = mem_gnt_i & slot_free;

  assign issue  = mem_req_o & mem_gnt_i;
  assign retire = resp_valid_o & resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_q + CNT_W'(issue) - CNT_W'(retire);
    end
  end

  // Response buffer, falls through in the rvalid cycle.
  // Room is guaranteed by the credit count.
  stream_buffer #(
    .T     ( axi_mem_pkg::data_t    ),
    .DEPTH ( axi_mem_pkg::BUF_DEPTH )
  ) resp_buf (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .data_i  ( mem_rdata_i  ),
    .valid_i ( mem_rvalid_i ),
    .ready_o (              ),
    .data_o  ( resp_o       ),
    .valid_o ( resp_valid_o ),
    .ready_i ( resp_ready_i )
  );

endmodule

`default_nettype wire

// ==== design/resp_router.sv ====
// Response router.
// Joins memory response data with the buffered beat description and steers
// the pair to R for reads or to B for the last write beat of a burst.
// Other write beats are dropped. All responses are OKAY.
`timescale 1ns/1ps
`default_nettype none

module resp_router (
  input  axi_mem_pkg::beat_meta_t meta_i,
  input  wire logic               meta_valid_i,
  output logic                    meta_ready_o,
  input  axi_mem_pkg::data_t      data_i,
  input  wire logic               data_valid_i,
  output logic                    data_ready_o,
  output axi_mem_pkg::b_chan_t    b_o,
  output logic                    b_valid_o,
  input  wire logic               b_ready_i,
  output axi_mem_pkg::r_chan_t    r_o,
  output logic                    r_valid_o,
  input  wire logic               r_ready_i
);

  logic join_valid, join_ready;
  logic to_r, to_b;

  assign join_valid = meta_valid_i & data_valid_i;

  assign to_r = ~meta_i.write;
  assign to_b = meta_i.write & meta_i.last;

  assign r_valid_o = join_valid & to_r;
  assign b_valid_o = join_valid & to_b;

  // Intermediate write beats need no sink.
  assign join_ready = to_r ? r_ready_i : (to_b ? b_ready_i : 1'b1);

  // Both sides are consumed together.
  assign meta_ready_o = data_valid_i & join_ready;
  assign data_ready_o = meta_valid_i & join_ready;

  assign b_o.id   = meta_i.id;
  assign b_o.resp = axi_mem_pkg::RESP_OKAY;

  assign r_o.id   = meta_i.id;
  assign r_o.data = data_i;
  assign r_o.resp = axi_mem_pkg::RESP_OKAY;
  assign r_o.last = meta_i.last;

endmodule

`default_nettype wire

// ==== design/axi_mem_bridge.sv ====
// AXI4 slave to memory bridge.
// Splits read and write bursts into single-beat memory requests,
// arbitrates between both directions and returns one B per write burst
// and one R per read beat.
`timescale 1ns/1ps
`default_nettype none

module axi_mem_bridge (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  axi_mem_pkg::ax_chan_t   aw_i,
  input  wire logic               aw_valid_i,
  output logic                    aw_ready_o,
  input  axi_mem_pkg::w_chan_t    w_i,
  input  wire logic               w_valid_i,
  output logic                    w_ready_o,
  output axi_mem_pkg::b_chan_t    b_o,
  output logic                    b_valid_o,
  input  wire logic               b_ready_i,
  input  axi_mem_pkg::ax_chan_t   ar_i,
  input  wire logic               ar_valid_i,
  output logic                    ar_ready_o,
  output axi_mem_pkg::r_chan_t    r_o,
  output logic                    r_valid_o,
  input  wire logic               r_ready_i,
  output axi_mem_pkg::mem_req_t   mem_o,
  output logic                    mem_req_o,
  input  wire logic               mem_gnt_i,
  input  wire logic               mem_rvalid_i,
  input  axi_mem_pkg::data_t      mem_rdata_i
);

  axi_mem_pkg::beat_meta_t rd_beat, wr_beat, arb_meta, buf_meta;
  axi_mem_pkg::mem_req_t   arb_req;
  axi_mem_pkg::data_t      resp_data;
  logic rd_valid, rd_ready, rd_active;
  logic wr_valid, wr_ready, wr_active;
  logic arb_meta_valid, arb_meta_ready;
  logic arb_req_valid, arb_req_ready;
  logic buf_valid, buf_ready;
  logic resp_valid, resp_ready;

  // Reads do not wait for W.
  axi_burst_gen #(.IS_WRITE(1'b0)) rd_gen (
    .clk_i          ( clk_i      ),
    .rst_n_i        ( rst_n_i    ),
    .ax_i           ( ar_i       ),
    .ax_valid_i     ( ar_valid_i ),
    .ax_ready_o     ( ar_ready_o ),
    .w_valid_i      ( 1'b1       ),
    .beat_o         ( rd_beat    ),
    .beat_valid_o   ( rd_valid   ),
    .beat_ready_i   ( rd_ready   ),
    .burst_active_o ( rd_active  )
  );

  axi_burst_gen #(.IS_WRITE(1'b1)) wr_gen (
    .clk_i          ( clk_i      ),
    .rst_n_i        ( rst_n_i    ),
    .ax_i           ( aw_i       ),
    .ax_valid_i     ( aw_valid_i ),
    .ax_ready_o     ( aw_ready_o ),
    .w_valid_i      ( w_valid_i  ),
    .beat_o         ( wr_beat    ),
    .beat_valid_o   ( wr_valid   ),
    .beat_ready_i   ( wr_ready   ),
    .burst_active_o ( wr_active  )
  );

  beat_arbiter arb (
    .clk_i        ( clk_i          ),
    .rst_n_i      ( rst_n_i        ),
    .rd_beat_i    ( rd_beat        ),
    .rd_valid_i   ( rd_valid       ),
    .rd_ready_o   ( rd_ready       ),
    .wr_beat_i    ( wr_beat        ),
    .wr_valid_i   ( wr_valid       ),
    .wr_ready_o   ( wr_ready       ),
    .rd_active_i  ( rd_active      ),
    .wr_active_i  ( wr_active      ),
    .w_i          ( w_i            ),
    .w_ready_o    ( w_ready_o      ),
    .meta_o       ( arb_meta       ),
    .meta_valid_o ( arb_meta_valid ),
    .meta_ready_i ( arb_meta_ready ),
    .mem_req_o    ( arb_req        ),
    .mem_valid_o  ( arb_req_valid  ),
    .mem_ready_i  ( arb_req_ready  )
  );

  // One entry more than requests in flight, so the fork never waits on it.
  stream_buffer #(
    .T     ( axi_mem_pkg::beat_meta_t   ),
    .DEPTH ( axi_mem_pkg::BUF_DEPTH + 1 )
  ) meta_buf (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .data_i  ( arb_meta       ),
    .valid_i ( arb_meta_valid ),
    .ready_o ( arb_meta_ready ),
    .data_o  ( buf_meta       ),
    .valid_o ( buf_valid      ),
    .ready_i ( buf_ready      )
  );

  mem_req_port mem_port (
    .clk_i        ( clk_i         ),
    .rst_n_i      ( rst_n_i       ),
    .req_i        ( arb_req       ),
    .req_valid_i  ( arb_req_valid ),
    .req_ready_o  ( arb_req_ready ),
    .resp_o       ( resp_data     ),
    .resp_valid_o ( resp_valid    ),
    .resp_ready_i ( resp_ready    ),
    .mem_o        ( mem_o         ),
    .mem_req_o    ( mem_req_o     ),
    .mem_gnt_i    ( mem_gnt_i     ),
    .mem_rvalid_i ( mem_rvalid_i  ),
    .mem_rdata_i  ( mem_rdata_i   )
  );

  resp_router router (
    .meta_i       ( buf_meta   ),
    .meta_valid_i ( buf_valid  ),
    .meta_ready_o ( buf_ready  ),
    .data_i       ( resp_data  ),
    .data_valid_i ( resp_valid ),
    .data_ready_o ( resp_ready ),
    .b_o          ( b_o        ),
    .b_valid_o    ( b_valid_o  ),
    .b_ready_i    ( b_ready_i  ),
    .r_o          ( r_o        ),
    .r_valid_o    ( r_valid_o  ),
    .r_ready_i    ( r_ready_i  )
  );

endmodule

`default_nettype wire

// ==== bench/axi_mem_bridge_properties.sv ====
// Handshake properties for the AXI memory bridge.
// Bound into the bridge. Checks R and B stability under back-pressure,
// the memory request during reset and the in-flight request limit.
`timescale 1ns/1ps
`default_nettype none

module axi_mem_bridge_properties (
  input wire logic                 clk_i,
  input wire logic                 rst_n_i,
  input wire axi_mem_pkg::r_chan_t r_o,
  input wire logic                 r_valid_o,
  input wire logic                 r_ready_i,
  input wire axi_mem_pkg::b_chan_t b_o,
  input wire logic                 b_valid_o,
  input wire logic                 b_ready_i,
  input wire logic                 mem_req_o,
  input wire logic                 mem_gnt_i,
  input wire logic                 mem_rvalid_i
);

  // Granted requests still waiting for rvalid.
  logic [3:0] in_flight_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + 4'(mem_req_o & mem_gnt_i) - 4'(mem_rvalid_i);
    end
  end

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R changed while stalled.");

  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else $error("B changed while stalled.");

  req_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !mem_req_o)
    else $error("Memory request during reset.");

  in_flight_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_flight_q <= 4'(axi_mem_pkg::BUF_DEPTH))
    else $error("Too many memory requests in flight.");

endmodule

bind axi_mem_bridge axi_mem_bridge_properties props0 (
  .clk_i        ( clk_i        ),
  .rst_n_i      ( rst_n_i      ),
  .r_o          ( r_o          ),
  .r_valid_o    ( r_valid_o    ),
  .r_ready_i    ( r_ready_i    ),
  .b_o          ( b_o          ),
  .b_valid_o    ( b_valid_o    ),
  .b_ready_i    ( b_ready_i    ),
  .mem_req_o    ( mem_req_o    ),
  .mem_gnt_i    ( mem_gnt_i    ),
  .mem_rvalid_i ( mem_rvalid_i )
);

`default_nettype wire

// ==== bench/axi_mem_bridge_tb.sv ====
// Testbench for the AXI4 memory bridge.
// Applies a table of write and read bursts against a memory model with
// random grant and latency, with random R and B back-pressure.
// Checks read data, ids, last flags, B responses and memory addresses.
`timescale 1ns/1ps
`default_nettype none

module axi_mem_bridge_tb;

  localparam int unsigned N_TXN = 12;

  // One burst; sync waits for all earlier rows to complete.
  typedef struct packed {
    logic                 wr;
    logic                 sync;
    axi_mem_pkg::id_t     id;
    axi_mem_pkg::addr_t   addr;
    axi_mem_pkg::len_t    len;
    axi_mem_pkg::size_t   size;
    logic [31:0]          seed;
  } txn_t;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  axi_mem_pkg::ax_chan_t   aw_i, ar_i;
  axi_mem_pkg::w_chan_t    w_i;
  logic                    aw_valid_i, ar_valid_i, w_valid_i, b_ready_i, r_ready_i;
  logic                    aw_ready_o, ar_ready_o, w_ready_o, b_valid_o, r_valid_o;
  axi_mem_pkg::b_chan_t    b_o;
  axi_mem_pkg::r_chan_t    r_o;
  axi_mem_pkg::mem_req_t   mem_o;
  logic                    mem_req_o, mem_gnt_i, mem_rvalid_i;
  axi_mem_pkg::data_t      mem_rdata_i;

  txn_t                    txns [N_TXN];
  logic                    txn_done [N_TXN];
  // Memory model contents and the expected contents, word indexed.
  axi_mem_pkg::data_t      model_mem [16384];
  axi_mem_pkg::data_t      ref_mem [16384];
  int                      rd_pending [$];
  int                      wr_pending [$];
  axi_mem_pkg::addr_t      exp_rd_addr [$];
  axi_mem_pkg::addr_t      exp_wr_addr [$];
  axi_mem_pkg::data_t      resp_data_q [$];
  int                      resp_due_q [$];
  int                      cyc = 0;
  int                      cyc_limit = 1000;
  int                      last_due = 0;
  int                      r_beat = 0;
  int                      b_cnt = 0;

  always #10 clk_i = ~clk_i;

  axi_mem_bridge dut0 (.*);

  // First beat at the given address, later beats step from the aligned one.
  function automatic axi_mem_pkg::addr_t beat_addr(input axi_mem_pkg::addr_t a,
                                                   input axi_mem_pkg::size_t s,
                                                   input int k);
    axi_mem_pkg::addr_t step;
    step = axi_mem_pkg::addr_t'(1 << s);
    if (k == 0) begin
      return a;
    end
    return (a & ~(step - 16'd1)) + axi_mem_pkg::addr_t'(k) * step;
  endfunction

  // Lanes from the start byte to the end of the size container.
  function automatic axi_mem_pkg::strb_t lane_mask(input axi_mem_pkg::addr_t a,
                                                   input axi_mem_pkg::size_t s);
    int lo;
    int hi;
    lo = a[1:0];
    hi = (a[1:0] & ~((1 << s) - 1)) + (1 << s) - 1;
    return axi_mem_pkg::strb_t'(((1 << (hi + 1)) - 1) & ~((1 << lo) - 1));
  endfunction

  function automatic axi_mem_pkg::data_t beat_data(input logic [31:0] seed, input int k);
    return (seed * 32'h0101_0101) ^ (32'(k) * 32'h1357_9bdf) ^ 32'h5a00_00a5;
  endfunction

  // Background pattern, depends on the whole word index.
  function automatic axi_mem_pkg::data_t fill_word(input int idx);
    return {~idx[15:0], idx[15:0]};
  endfunction

  function automatic axi_mem_pkg::data_t merge_bytes(input axi_mem_pkg::data_t old_w,
                                                     input axi_mem_pkg::data_t new_w,
                                                     input axi_mem_pkg::strb_t strb);
    axi_mem_pkg::data_t res;
    int b;
    res = old_w;
    for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic prior_done(input int n);
    int j;
    for (j = 0; j < n; j++) begin
      if (!txn_done[j]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s.", what);
    end
  endtask

  task automatic drive_w_beat(input txn_t t, input int k);
    w_i.data   = beat_data(t.seed, k);
    w_i.strb   = lane_mask(beat_addr(t.addr, t.size, k), t.size);
    w_i.last   = (k == t.len);
    w_valid_i  = 1'b1;
  endtask

  // AW and the first W go out together, W beats follow back to back.
  task automatic run_write(input int i);
    txn_t               t;
    int                 k;
    logic               aw_hs;
    logic               w_hs;
    axi_mem_pkg::addr_t a;
    t = txns[i];
    @(negedge clk_i);
    for (k = 0; k <= t.len; k++) begin
      exp_wr_addr.push_back(beat_addr(t.addr, t.size, k));
    end
    wr_pending.push_back(i);
    aw_i       = '{id: t.id, addr: t.addr, len: t.len, size: t.size};
    aw_valid_i = 1'b1;
    k = 0;
    drive_w_beat(t, 0);
    while (k <= t.len) begin
      @(posedge clk_i);
      aw_hs = aw_valid_i & aw_ready_o;
      w_hs  = w_valid_i & w_ready_o;
      // AW is taken on the same edge as the first W beat.
      if (k == 0) begin
        check(aw_hs, w_hs, "AW accepted apart from the first W");
      end
      @(negedge clk_i);
      if (aw_hs) begin
        aw_valid_i = 1'b0;
      end
      if (w_hs) begin
        a = beat_addr(t.addr, t.size, k);
        ref_mem[a[15:2]] = merge_bytes(ref_mem[a[15:2]], w_i.data, w_i.strb);
        k++;
        if (k <= t.len) begin
          drive_w_beat(t, k);
        end else begin
          w_valid_i = 1'b0;
        end
      end
    end
  endtask

  task automatic run_read(input int i);
    txn_t t;
    int   k;
    t = txns[i];
    @(negedge clk_i);
    for (k = 0; k <= t.len; k++) begin
      exp_rd_addr.push_back(beat_addr(t.addr, t.size, k));
    end
    rd_pending.push_back(i);
    ar_i       = '{id: t.id, addr: t.addr, len: t.len, size: t.size};
    ar_valid_i = 1'b1;
    @(posedge clk_i);
    while (!ar_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // Cycle count, timeout, memory grant and rvalid, random R and B ready.
  always @(negedge clk_i) begin
    cyc = cyc + 1;
    if (cyc >= cyc_limit) begin
      $display("Timeout after %0d cycles, bursts are still pending.", cyc);
      $display(">>> FAIL");
      $fatal(1, "Timeout.");
    end else begin
      mem_gnt_i = ($urandom % 4) != 0;
      r_ready_i = ($urandom % 3) != 0;
      b_ready_i = ($urandom % 3) != 0;
      if (resp_due_q.size() != 0 && resp_due_q[0] == cyc) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = resp_data_q.pop_front();
        void'(resp_due_q.pop_front());
      end else begin
        mem_rvalid_i = 1'b0;
      end
    end
  end

  // Memory model, answers in order 1 to 4 cycles after the grant.
  always @(posedge clk_i) begin : mem_model
    axi_mem_pkg::addr_t exp_a;
    int                 due;
    if (rst_n_i && mem_req_o && mem_gnt_i) begin
      if (mem_o.we) begin
        check(exp_wr_addr.size() != 0, 1, "write request without a pending beat");
        exp_a = exp_wr_addr.pop_front();
        check(mem_o.addr, exp_a, "write beat address");
        model_mem[mem_o.addr[15:2]] = merge_bytes(model_mem[mem_o.addr[15:2]],
                                                  mem_o.wdata, mem_o.strb);
      end else begin
        check(exp_rd_addr.size() != 0, 1, "read request without a pending beat");
        exp_a = exp_rd_addr.pop_front();
        check(mem_o.addr, exp_a, "read beat address");
      end
      due = cyc + 1 + int'($urandom % 4);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      resp_data_q.push_back(model_mem[mem_o.addr[15:2]]);
      resp_due_q.push_back(due);
    end
  end

  // R and B checks against the pending bursts, in issue order.
  always @(posedge clk_i) begin : resp_monitor
    txn_t                t;
    axi_mem_pkg::addr_t  a;
    axi_mem_pkg::strb_t  m;
    int                  idx;
    int                  b;
    if (rst_n_i && r_valid_o && r_ready_i) begin
      check(rd_pending.size() != 0, 1, "R beat without a pending read");
      idx = rd_pending[0];
      t   = txns[idx];
      check(r_o.id, t.id, "R id");
      check(r_o.resp, axi_mem_pkg::RESP_OKAY, "R resp");
      check(r_o.last, r_beat == t.len, "R last");
      a = beat_addr(t.addr, t.size, r_beat);
      m = lane_mask(a, t.size);
      for (b = 0; b < 4; b++) begin
        if (m[b]) begin
          check(r_o.data[8*b +: 8], ref_mem[a[15:2]][8*b +: 8], "R data byte");
        end
      end
      if (r_beat == t.len) begin
        r_beat        = 0;
        txn_done[idx] = 1'b1;
        void'(rd_pending.pop_front());
      end else begin
        r_beat++;
      end
    end
    if (rst_n_i && b_valid_o && b_ready_i) begin
      check(wr_pending.size() != 0, 1, "B without a pending write");
      idx = wr_pending.pop_front();
      check(b_o.id, txns[idx].id, "B id");
      check(b_o.resp, axi_mem_pkg::RESP_OKAY, "B resp");
      txn_done[idx] = 1'b1;
      b_cnt++;
    end
  end

  initial begin
    int n_wr;
    int n_beats;
    int i;
    void'($urandom(32'h733f9d2b));
    rst_n_i      = 1'b0;
    aw_i         = '0;
    ar_i         = '0;
    w_i          = '0;
    aw_valid_i   = 1'b0;
    ar_valid_i   = 1'b0;
    w_valid_i    = 1'b0;
    b_ready_i    = 1'b0;
    r_ready_i    = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    // Write, read back, narrow and unaligned bursts, then mixed traffic.
    txns[0]  = '{wr: 1, sync: 0, id: 1,  addr: 16'h0100, len: 7,  size: 2, seed: 32'h11};
    txns[1]  = '{wr: 0, sync: 1, id: 2,  addr: 16'h0100, len: 7,  size: 2, seed: 32'h0};
    txns[2]  = '{wr: 1, sync: 0, id: 3,  addr: 16'h0203, len: 5,  size: 0, seed: 32'h22};
    txns[3]  = '{wr: 1, sync: 0, id: 4,  addr: 16'h0301, len: 4,  size: 1, seed: 32'h33};
    txns[4]  = '{wr: 0, sync: 1, id: 5,  addr: 16'h0203, len: 5,  size: 0, seed: 32'h0};
    txns[5]  = '{wr: 0, sync: 0, id: 6,  addr: 16'h0301, len: 4,  size: 1, seed: 32'h0};
    txns[6]  = '{wr: 1, sync: 0, id: 7,  addr: 16'h0402, len: 15, size: 2, seed: 32'h44};
    txns[7]  = '{wr: 0, sync: 0, id: 8,  addr: 16'h0100, len: 7,  size: 2, seed: 32'h0};
    txns[8]  = '{wr: 1, sync: 0, id: 9,  addr: 16'h0500, len: 0,  size: 2, seed: 32'h55};
    txns[9]  = '{wr: 0, sync: 0, id: 10, addr: 16'h0301, len: 4,  size: 1, seed: 32'h0};
    txns[10] = '{wr: 0, sync: 1, id: 11, addr: 16'h0402, len: 15, size: 2, seed: 32'h0};
    txns[11] = '{wr: 0, sync: 0, id: 12, addr: 16'h0500, len: 0,  size: 2, seed: 32'h0};
    n_wr    = 0;
    n_beats = 0;
    for (i = 0; i < N_TXN; i++) begin
      txn_done[i] = 1'b0;
      n_wr        = n_wr + int'(txns[i].wr);
      n_beats     = n_beats + int'(txns[i].len) + 1;
    end
    cyc_limit = 1000 + 30 * n_beats;
    for (i = 0; i < 16384; i++) begin
      model_mem[i] = fill_word(i);
      ref_mem[i]   = fill_word(i);
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // Write and read channels run side by side.
    fork
      begin
        for (int w = 0; w < N_TXN; w++) begin
          if (txns[w].wr) begin
            while (txns[w].sync && !prior_done(w)) @(negedge clk_i);
            run_write(w);
          end
        end
      end
      begin
        for (int r = 0; r < N_TXN; r++) begin
          if (!txns[r].wr) begin
            while (txns[r].sync && !prior_done(r)) @(negedge clk_i);
            run_read(r);
          end
        end
      end
    join
    while (!prior_done(N_TXN)) @(negedge clk_i);
    check(exp_wr_addr.size(), 0, "write beats never sent to memory");
    check(exp_rd_addr.size(), 0, "read beats never sent to memory");
    check(resp_due_q.size(), 0, "memory responses left over");
    check(b_cnt, n_wr, "B count");
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== axi_mem_bridge.f ====
design/axi_mem_pkg.sv
design/stream_buffer.sv
design/axi_burst_gen.sv
design/beat_arbiter.sv
design/mem_req_port.sv
design/resp_router.sv
design/axi_mem_bridge.sv
bench/axi_mem_bridge_properties.sv
bench/axi_mem_bridge_tb.sv
